//--- common/conv_pkg.sv
// convolution datapath geometry
// sample and word widths, buffer sizes and the operand bundle
// that runs from the tap buffer into the MAC lanes
package conv_pkg;

  // sample and host word widths
  localparam int BYTE_W = 8;
  localparam int WORD_W = 32;

  // two 4-byte lanes per step
  localparam int LANES = 2;
  localparam int STEP_BYTES = LANES * WORD_W / BYTE_W;

  localparam int KERNEL_LENGTH = 8;
  localparam int MAX_CHANNELS = 32;

  // memories hold one step (a word pair) per entry
  localparam int FILTER_PAIRS = KERNEL_LENGTH * MAX_CHANNELS / STEP_BYTES;
  // input ring keeps one spare row for writes during a run
  localparam int INPUT_PAIRS = (KERNEL_LENGTH + 1) * MAX_CHANNELS / STEP_BYTES;

  // byte address into either buffer
  localparam int ADDR_W = 10;
  localparam int FILTER_IDX_W = $clog2(FILTER_PAIRS);
  localparam int INPUT_IDX_W = $clog2(INPUT_PAIRS);

  typedef logic signed [BYTE_W-1:0] conv_byte_t;

  // host writes see a raw word, lanes see four signed samples
  // byte 0 sits in the low bits
  typedef union packed {
    logic [WORD_W-1:0] raw;
    conv_byte_t [WORD_W/BYTE_W-1:0] bytes;
  } conv_word_u;

  // one step of the MAC, tags travel with the data
  typedef struct packed {
    logic valid;
    logic last;
    conv_word_u [LANES-1:0] filter_pair;
    conv_word_u [LANES-1:0] input_pair;
  } mac_operand_t;

endpackage

//--- common/cfu_cmd_pkg.sv
// host command interface
// command codes, the request word and the register bundles
// that leave the command decoder
package cfu_cmd_pkg;

  localparam int CMD_W = 7;

  localparam logic [CMD_W-1:0] CMD_PROBE = 7'd0;
  localparam logic [CMD_W-1:0] CMD_WR_INPUT = 7'd1;
  localparam logic [CMD_W-1:0] CMD_WR_FILTER = 7'd2;
  localparam logic [CMD_W-1:0] CMD_OFFSET = 7'd3;
  localparam logic [CMD_W-1:0] CMD_DEPTH = 7'd5;
  localparam logic [CMD_W-1:0] CMD_START = 7'd6;
  localparam logic [CMD_W-1:0] CMD_RESULT = 7'd7;
  localparam logic [CMD_W-1:0] CMD_START_X = 7'd8;
  localparam logic [CMD_W-1:0] CMD_STATUS = 7'd9;
  localparam logic [CMD_W-1:0] CMD_RING = 7'd16;

  // addr is inp0, value is inp1
  typedef struct packed {
    logic [CMD_W-1:0] cmd;
    logic [conv_pkg::WORD_W-1:0] addr;
    logic [conv_pkg::WORD_W-1:0] value;
  } cfu_req_t;

  // run parameters, held as levels between commands
  typedef struct packed {
    logic [conv_pkg::WORD_W-1:0] offset;
    logic [conv_pkg::ADDR_W-1:0] depth;
    logic [conv_pkg::ADDR_W-1:0] start_x;
    logic ring;
  } conv_cfg_t;

  // single cycle buffer write, byte addressed
  typedef struct packed {
    logic wr_input;
    logic wr_filter;
    logic [conv_pkg::ADDR_W-1:0] addr;
    logic [conv_pkg::WORD_W-1:0] data;
  } buf_wr_t;

endpackage

//--- design/cmd_regs.sv
// command decoder for the convolution accelerator
// holds the run parameters, forwards buffer writes and start,
// and answers probe, result and status reads on ret
`timescale 1ns/1ns

module cmd_regs (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           en,
  input  cfu_cmd_pkg::cfu_req_t          req,
  input  logic [conv_pkg::WORD_W-1:0]    result,
  input  logic                           done,
  output cfu_cmd_pkg::conv_cfg_t         cfg,
  output cfu_cmd_pkg::buf_wr_t           buf_wr,
  output logic                           start,
  output logic [conv_pkg::WORD_W-1:0]    ret
);

  // start is combinational so done drops on the same edge as the command
  assign start = en && (req.cmd == cfu_cmd_pkg::CMD_START);

  // buffer writes land on the edge that takes the command
  assign buf_wr.wr_input = en && (req.cmd == cfu_cmd_pkg::CMD_WR_INPUT);
  assign buf_wr.wr_filter = en && (req.cmd == cfu_cmd_pkg::CMD_WR_FILTER);
  assign buf_wr.addr = req.addr[conv_pkg::ADDR_W-1:0];
  assign buf_wr.data = req.value;

  always_ff @(posedge clk) begin
    if (reset) begin
      cfg.offset <= '0;
      cfg.depth <= '0;
      cfg.start_x <= '0;
      cfg.ring <= 1'b0;
      ret <= '0;
    end else if (en) begin
      case (req.cmd)
        cfu_cmd_pkg::CMD_PROBE: begin
          // bytes consumed per step
          ret <= conv_pkg::WORD_W'(conv_pkg::STEP_BYTES);
        end
        cfu_cmd_pkg::CMD_WR_INPUT,
        cfu_cmd_pkg::CMD_WR_FILTER,
        cfu_cmd_pkg::CMD_START: begin
          // handled by the strobes above, ret keeps its value
        end
        cfu_cmd_pkg::CMD_OFFSET: begin
          cfg.offset <= req.value;
        end
        cfu_cmd_pkg::CMD_DEPTH: begin
          // channel depth, multiple of 8 up to MAX_CHANNELS
          cfg.depth <= req.value[conv_pkg::ADDR_W-1:0];
        end
        cfu_cmd_pkg::CMD_RESULT: begin
          ret <= result;
        end
        cfu_cmd_pkg::CMD_START_X: begin
          // window position in rows of the input ring
          cfg.start_x <= req.value[conv_pkg::ADDR_W-1:0];
        end
        cfu_cmd_pkg::CMD_STATUS: begin
          ret <= conv_pkg::WORD_W'(done);
        end
        cfu_cmd_pkg::CMD_RING: begin
          // ring mode adds a spare row to the input buffer
          cfg.ring <= req.value[0];
        end
        default: begin
          ret <= '0;
        end
      endcase
    end
  end

endmodule

//--- mac/tap_buffer.sv
// filter and input sample memories
// each entry is a word pair, one step of the MAC
// host writes fill one word of a pair, reads return a full pair
// one cycle later with the valid and last tags kept aligned
`timescale 1ns/1ns

module tap_buffer (
  input  logic                                 clk,
  input  cfu_cmd_pkg::buf_wr_t                 buf_wr,
  input  logic [conv_pkg::FILTER_IDX_W-1:0]    filter_addr,
  input  logic [conv_pkg::INPUT_IDX_W-1:0]     input_addr,
  input  logic                                 rd_valid,
  input  logic                                 rd_last,
  output conv_pkg::mac_operand_t               operand
);

  // block ram style arrays
  conv_pkg::conv_word_u [conv_pkg::LANES-1:0] filter_mem [conv_pkg::FILTER_PAIRS];
  conv_pkg::conv_word_u [conv_pkg::LANES-1:0] input_mem [conv_pkg::INPUT_PAIRS];

  logic [conv_pkg::FILTER_IDX_W-1:0] filter_wr_idx;
  logic [conv_pkg::INPUT_IDX_W-1:0] input_wr_idx;
  logic wr_half;

  // byte address, bits above 3 pick the pair
  assign filter_wr_idx = buf_wr.addr[3 +: conv_pkg::FILTER_IDX_W];
  assign input_wr_idx = buf_wr.addr[3 +: conv_pkg::INPUT_IDX_W];
  // bit 2 picks the word inside the pair
  assign wr_half = buf_wr.addr[2];

  always_ff @(posedge clk) begin
    if (buf_wr.wr_filter) begin
      filter_mem[filter_wr_idx][wr_half].raw <= buf_wr.data;
    end
    if (buf_wr.wr_input) begin
      input_mem[input_wr_idx][wr_half].raw <= buf_wr.data;
    end
  end

  // registered read port
  always_ff @(posedge clk) begin
    operand.valid <= rd_valid;
    operand.last <= rd_last;
    operand.filter_pair <= filter_mem[filter_addr];
    operand.input_pair <= input_mem[input_addr];
  end

endmodule

//--- mac/mac_sequencer.sv
// address walker for one dot product
// steps the filter and the input ring by one word pair per clock,
// wraps the input pointer at the ring length and tags the last step
`timescale 1ns/1ns

module mac_sequencer (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 start,
  input  cfu_cmd_pkg::conv_cfg_t               cfg,
  output logic [conv_pkg::FILTER_IDX_W-1:0]    filter_addr,
  output logic [conv_pkg::INPUT_IDX_W-1:0]     input_addr,
  output logic                                 rd_valid,
  output logic                                 rd_last
);

  logic running;
  // byte pointers, always a multiple of STEP_BYTES
  logic [conv_pkg::ADDR_W-1:0] filter_ptr;
  logic [conv_pkg::ADDR_W-1:0] input_ptr;
  logic [conv_pkg::ADDR_W-1:0] next_input;
  logic [conv_pkg::ADDR_W-1:0] kernel_len;
  logic [conv_pkg::ADDR_W-1:0] ring_len;
  logic is_last;

  // kernel covers KERNEL_LENGTH rows of depth samples
  assign kernel_len = cfg.depth * conv_pkg::ADDR_W'(conv_pkg::KERNEL_LENGTH);
  // ring mode keeps one spare row
  assign ring_len = kernel_len + (cfg.ring ? cfg.depth : '0);

  assign is_last = (filter_ptr + conv_pkg::ADDR_W'(conv_pkg::STEP_BYTES)) == kernel_len;

  always_comb begin
    next_input = input_ptr + conv_pkg::ADDR_W'(conv_pkg::STEP_BYTES);
    // depth is a multiple of 8 so the step lands exactly on the ring end
    if (next_input >= ring_len) begin
      next_input = next_input - ring_len;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      running <= 1'b0;
      filter_ptr <= '0;
      input_ptr <= '0;
    end else if (start) begin
      // a start while busy restarts the walk
      running <= 1'b1;
      filter_ptr <= '0;
      input_ptr <= cfg.start_x * cfg.depth;
    end else if (running) begin
      filter_ptr <= filter_ptr + conv_pkg::ADDR_W'(conv_pkg::STEP_BYTES);
      input_ptr <= next_input;
      if (is_last) begin
        running <= 1'b0;
      end
    end
  end

  assign filter_addr = filter_ptr[3 +: conv_pkg::FILTER_IDX_W];
  assign input_addr = input_ptr[3 +: conv_pkg::INPUT_IDX_W];

  // squash the read issued in the start cycle, it belongs to the old run
  assign rd_valid = running && !start;
  assign rd_last = rd_valid && is_last;

endmodule

//--- mac/mac_lane.sv
// one multiply-accumulate lane
// four signed int8 products per step, input samples shifted by the offset,
// summed into a 32-bit accumulator that clears on start
`timescale 1ns/1ns

module mac_lane (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              start,
  input  conv_pkg::conv_word_u              filter_word,
  input  conv_pkg::conv_word_u              input_word,
  input  logic                              valid,
  input  logic [conv_pkg::WORD_W-1:0]       offset,
  output logic signed [conv_pkg::WORD_W-1:0] lane_sum
);

  logic signed [conv_pkg::WORD_W-1:0] step_sum;

  // filter byte times (input byte + offset), over the four bytes
  always_comb begin
    step_sum = '0;
    for (int b = 0; b < conv_pkg::WORD_W / conv_pkg::BYTE_W; b++) begin
      step_sum = step_sum + $signed(filter_word.bytes[b]) *
                 ($signed(input_word.bytes[b]) + $signed(offset));
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      lane_sum <= '0;
    end else if (start) begin
      lane_sum <= '0;
    end else if (valid) begin
      // wraps at 32 bits like the host accumulator
      lane_sum <= lane_sum + step_sum;
    end
  end

endmodule

//--- design/acc_combine.sv
// end of run combiner
// adds the two lane sums once the last step has been accumulated,
// holds the result and raises the done level
`timescale 1ns/1ns

module acc_combine (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               start,
  input  logic                               last,
  input  logic signed [conv_pkg::WORD_W-1:0] lane_sum0,
  input  logic signed [conv_pkg::WORD_W-1:0] lane_sum1,
  output logic [conv_pkg::WORD_W-1:0]        result,
  output logic                               done
);

  // last tag one cycle behind the operand, the lanes have added it by then
  logic last_d;

  always_ff @(posedge clk) begin
    if (reset) begin
      last_d <= 1'b0;
      done <= 1'b1;
      result <= '0;
    end else if (start) begin
      // start wins over a pending last from an aborted run
      last_d <= 1'b0;
      done <= 1'b0;
    end else begin
      last_d <= last;
      if (last_d) begin
        result <= lane_sum0 + lane_sum1;
        done <= 1'b1;
      end
    end
  end

endmodule

//--- design/conv1d_top.sv
// 1-d convolution accelerator, custom instruction port
// command decode, address sequencer, tap buffers,
// two MAC lanes and the final combiner
`timescale 1ns/1ns

module conv1d_top (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              en,
  input  logic [cfu_cmd_pkg::CMD_W-1:0]     cmd,
  input  logic [conv_pkg::WORD_W-1:0]       inp0,
  input  logic [conv_pkg::WORD_W-1:0]       inp1,
  output logic [conv_pkg::WORD_W-1:0]       ret
);

  cfu_cmd_pkg::cfu_req_t req;
  cfu_cmd_pkg::conv_cfg_t cfg;
  cfu_cmd_pkg::buf_wr_t buf_wr;
  logic start;
  logic [conv_pkg::WORD_W-1:0] result;
  logic done;

  logic [conv_pkg::FILTER_IDX_W-1:0] filter_addr;
  logic [conv_pkg::INPUT_IDX_W-1:0] input_addr;
  logic rd_valid;
  logic rd_last;
  conv_pkg::mac_operand_t operand;
  logic signed [conv_pkg::WORD_W-1:0] lane_sum0;
  logic signed [conv_pkg::WORD_W-1:0] lane_sum1;

  assign req.cmd = cmd;
  assign req.addr = inp0;
  assign req.value = inp1;

  cmd_regs u_cmd_regs (
    .clk    (clk),
    .reset  (reset),
    .en     (en),
    .req    (req),
    .result (result),
    .done   (done),
    .cfg    (cfg),
    .buf_wr (buf_wr),
    .start  (start),
    .ret    (ret)
  );

  mac_sequencer u_mac_sequencer (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .cfg         (cfg),
    .filter_addr (filter_addr),
    .input_addr  (input_addr),
    .rd_valid    (rd_valid),
    .rd_last     (rd_last)
  );

  tap_buffer u_tap_buffer (
    .clk         (clk),
    .buf_wr      (buf_wr),
    .filter_addr (filter_addr),
    .input_addr  (input_addr),
    .rd_valid    (rd_valid),
    .rd_last     (rd_last),
    .operand     (operand)
  );

  // lane 0 takes the low word of each pair
  mac_lane u_lane0 (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .filter_word (operand.filter_pair[0]),
    .input_word  (operand.input_pair[0]),
    .valid       (operand.valid),
    .offset      (cfg.offset),
    .lane_sum    (lane_sum0)
  );

  mac_lane u_lane1 (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .filter_word (operand.filter_pair[1]),
    .input_word  (operand.input_pair[1]),
    .valid       (operand.valid),
    .offset      (cfg.offset),
    .lane_sum    (lane_sum1)
  );

  acc_combine u_acc_combine (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .last      (operand.last),
    .lane_sum0 (lane_sum0),
    .lane_sum1 (lane_sum1),
    .result    (result),
    .done      (done)
  );

endmodule

//--- bench/conv1d_chk.sv
// assertions on the convolution accelerator top level
// start clears done, reset clears ret, no operand while idle
`timescale 1ns/1ns

module conv1d_chk (
  input logic        clk,
  input logic        reset,
  input logic        start,
  input logic        done,
  input logic        op_valid,
  input logic [31:0] ret
);

  // done drops on the edge that takes the start
  assert property (@(posedge clk) disable iff (reset) start |=> !done)
    else $error("done still high in the cycle after a start");

  assert property (@(posedge clk) reset |=> (ret == 32'd0))
    else $error("ret not cleared in the cycle after reset");

  // operands only flow while a run is busy
  assert property (@(posedge clk) disable iff (reset) !(op_valid && done))
    else $error("operand valid while done is high");

endmodule

bind conv1d_top conv1d_chk u_conv1d_chk (
  .clk      (clk),
  .reset    (reset),
  .start    (start),
  .done     (done),
  .op_valid (operand.valid),
  .ret      (ret)
);

//--- bench/conv1d_tb.sv
// testbench for the 1-d convolution accelerator
// replays the case table and LFSR random cases through the command port,
// checks probe, status and results against a reference dot product
`timescale 1ns/1ns

module conv1d_tb;

  // depth offset start_x ring f_slope f_base i_slope i_base expected
  localparam int CASE_WORDS = 9;
  localparam int MAX_CASES = 16;
  localparam int RANDOM_CASES = 4;
  localparam int FILTER_BYTES = conv_pkg::KERNEL_LENGTH * conv_pkg::MAX_CHANNELS;
  localparam int INPUT_BYTES = (conv_pkg::KERNEL_LENGTH + 1) * conv_pkg::MAX_CHANNELS;

  logic clk = 1'b0;
  logic reset;
  logic en;
  logic [cfu_cmd_pkg::CMD_W-1:0] cmd;
  logic [31:0] inp0;
  logic [31:0] inp1;
  logic [31:0] ret;

  logic [31:0] case_mem [CASE_WORDS*MAX_CASES];
  logic signed [7:0] filter_bytes [FILTER_BYTES];
  logic signed [7:0] input_bytes [INPUT_BYTES];
  logic [31:0] lfsr = 32'h6a72_b3e1;
  int file_cases;
  int pass_count;
  int fail_count;

  always #4 clk = ~clk;

  conv1d_top UUT (
    .clk  (clk),
    .reset(reset),
    .en   (en),
    .cmd  (cmd),
    .inp0 (inp0),
    .inp1 (inp1),
    .ret  (ret)
  );

  // one command, held across one rising edge, returns 1 ns after it
  task automatic issue(input logic [6:0] code, input logic [31:0] a, input logic [31:0] v);
    cmd = code;
    inp0 = a;
    inp1 = v;
    en = 1'b1;
    @(posedge clk);
    #1;
    en = 1'b0;
  endtask

  // ret holds the answer once the command edge has passed
  task automatic read_reg(input logic [6:0] code, output logic [31:0] value);
    issue(code, 32'd0, 32'd0);
    value = ret;
  endtask

  // fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      value = {value[30:0], lfsr[0]};
    end
  endtask

  // sum of filter[k] * (input[(start_x*depth + k) mod ring] + offset), 32-bit wrap
  function automatic int model_sum(input int depth, input int offset, input int sx,
                                   input bit ring);
    int ring_len;
    int acc;
    ring_len = (conv_pkg::KERNEL_LENGTH + ring) * depth;
    acc = 0;
    for (int k = 0; k < conv_pkg::KERNEL_LENGTH * depth; k++) begin
      acc += int'(filter_bytes[k]) *
             (int'(input_bytes[(sx * depth + k) % ring_len]) + offset);
    end
    return acc;
  endfunction

  // affine byte pattern over the byte address, wraps at 8 bits
  task automatic fill_pattern(input int depth, input logic [7:0] fa, input logic [7:0] fb,
                              input logic [7:0] ia, input logic [7:0] ib);
    for (int a = 0; a < conv_pkg::KERNEL_LENGTH * depth; a++) begin
      filter_bytes[a] = 8'(fa * a + fb);
    end
    for (int a = 0; a < (conv_pkg::KERNEL_LENGTH + 1) * depth; a++) begin
      input_bytes[a] = 8'(ia * a + ib);
    end
  endtask

  task automatic report(input string name, input bit ok);
    if (ok) begin
      pass_count++;
      $display("%s: ok", name);
    end else begin
      fail_count++;
      $display("%s: FAILED", name);
    end
  endtask

  task automatic run_case(input string name, input int depth, input int offset, input int sx,
                          input bit ring, input logic [31:0] expected);
    int ring_len;
    int polls;
    logic [31:0] value;
    bit ok;
    ring_len = (conv_pkg::KERNEL_LENGTH + ring) * depth;
    ok = 1'b1;
    issue(cfu_cmd_pkg::CMD_DEPTH, 32'd0, depth);
    issue(cfu_cmd_pkg::CMD_OFFSET, 32'd0, offset);
    issue(cfu_cmd_pkg::CMD_START_X, 32'd0, sx);
    issue(cfu_cmd_pkg::CMD_RING, 32'd0, 32'(ring));
    // four samples per word, byte 0 in the low bits
    for (int a = 0; a < conv_pkg::KERNEL_LENGTH * depth; a += 4) begin
      issue(cfu_cmd_pkg::CMD_WR_FILTER, a, {filter_bytes[a+3], filter_bytes[a+2],
            filter_bytes[a+1], filter_bytes[a]});
    end
    for (int a = 0; a < ring_len; a += 4) begin
      issue(cfu_cmd_pkg::CMD_WR_INPUT, a, {input_bytes[a+3], input_bytes[a+2],
            input_bytes[a+1], input_bytes[a]});
    end
    if (model_sum(depth, offset, sx, ring) != expected) begin
      $display("ERR at %0t ns: %s model gives %h, table gives %h", $time, name,
               model_sum(depth, offset, sx, ring), expected);
      ok = 1'b0;
    end
    issue(cfu_cmd_pkg::CMD_START, 32'd0, 32'd0);
    read_reg(cfu_cmd_pkg::CMD_STATUS, value);
    if (value != 32'd0) begin
      $display("ERR at %0t ns: %s status %h right after start", $time, name, value);
      ok = 1'b0;
    end
    // run takes depth steps plus a couple of cycles
    polls = 0;
    while (value != 32'd1 && polls < 2 * depth + 20) begin
      read_reg(cfu_cmd_pkg::CMD_STATUS, value);
      polls++;
    end
    if (value != 32'd1) begin
      $display("%s: run never reported done after %0d status polls", name, polls);
      ok = 1'b0;
    end
    read_reg(cfu_cmd_pkg::CMD_RESULT, value);
    if (value != expected) begin
      $display("ERR at %0t ns: %s result %h, expected %h", $time, name, value, expected);
      ok = 1'b0;
    end
    report(name, ok);
  endtask

  initial begin
    logic [31:0] value;
    logic [31:0] bits;
    bit ok;
    int base;
    int depth;
    int offset;
    int sx;
    bit ring;
    reset = 1'b1;
    en = 1'b0;
    cmd = '0;
    inp0 = '0;
    inp1 = '0;
    pass_count = 0;
    fail_count = 0;
    file_cases = 0;
    for (int i = 0; i < CASE_WORDS * MAX_CASES; i++) begin
      case_mem[i] = '0;
    end
    $readmemh("bench/conv1d_cases.txt", case_mem);
    // a zero depth ends the table
    while (file_cases < MAX_CASES && case_mem[file_cases*CASE_WORDS] != 32'd0) begin
      file_cases++;
    end
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;

    // probe, unknown code and idle status
    ok = 1'b1;
    read_reg(cfu_cmd_pkg::CMD_PROBE, value);
    if (value != 32'd8) begin
      $display("ERR at %0t ns: probe returned %h, expected 8", $time, value);
      ok = 1'b0;
    end
    read_reg(7'd4, value);
    if (value != 32'd0) begin
      $display("ERR at %0t ns: unknown code returned %h, expected 0", $time, value);
      ok = 1'b0;
    end
    read_reg(cfu_cmd_pkg::CMD_STATUS, value);
    if (value != 32'd1) begin
      $display("ERR at %0t ns: status after reset %h, expected 1", $time, value);
      ok = 1'b0;
    end
    report("probe and idle status", ok);

    for (int c = 0; c < file_cases; c++) begin
      base = c * CASE_WORDS;
      fill_pattern(case_mem[base], case_mem[base+4][7:0], case_mem[base+5][7:0],
                   case_mem[base+6][7:0], case_mem[base+7][7:0]);
      run_case($sformatf("table case %0d", c), case_mem[base], case_mem[base+1],
               case_mem[base+2], case_mem[base+3][0], case_mem[base+8]);
    end

    for (int r = 0; r < RANDOM_CASES; r++) begin
      draw_bits(2, bits);
      depth = 8 * (int'(bits) + 1);
      draw_bits(1, bits);
      ring = bits[0];
      draw_bits(3, bits);
      sx = int'(bits);
      draw_bits(8, bits);
      offset = int'($signed(bits[7:0]));
      for (int a = 0; a < conv_pkg::KERNEL_LENGTH * depth; a++) begin
        draw_bits(8, bits);
        filter_bytes[a] = bits[7:0];
      end
      for (int a = 0; a < (conv_pkg::KERNEL_LENGTH + 1) * depth; a++) begin
        draw_bits(8, bits);
        input_bytes[a] = bits[7:0];
      end
      run_case($sformatf("random case %0d", r), depth, offset, sx, ring,
               model_sum(depth, offset, sx, ring));
    end

    $display("tests passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // budget per test sized for the largest depth
  initial begin
    int limit;
    wait (reset === 1'b0);
    limit = (1 + file_cases + RANDOM_CASES) * (2 * conv_pkg::MAX_CHANNELS + 200);
    repeat (limit) @(posedge clk);
    $display("timeout: tests did not finish within %0d cycles", limit);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- bench/conv1d_cases.txt
// depth offset start_x ring f_slope f_base i_slope i_base expected, all hex
// buffer byte at address a is slope*a + base on 8 bits, expected is the 32-bit sum
00000008 00000000 00000000 00000000 01 E0 01 E0 00005560
00000020 00000000 00000000 00000000 01 80 01 80 00155580
00000008 00000005 00000000 00000000 01 E0 01 E0 000054C0
00000020 FFFFFFFF 00000000 00000000 01 80 01 80 00155600
00000008 00000000 00000005 00000000 01 E0 01 E0 FFFFDD60
00000008 00000000 00000005 00000001 01 E0 01 E0 FFFFC4E0
00000008 00000000 00000000 00000000 FF 1F 01 E0 FFFFAAC0

//--- verilog.f
common/conv_pkg.sv
common/cfu_cmd_pkg.sv
design/cmd_regs.sv
mac/tap_buffer.sv
mac/mac_sequencer.sv
mac/mac_lane.sv
design/acc_combine.sv
design/conv1d_top.sv
bench/conv1d_chk.sv
bench/conv1d_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the convolution testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal -f verilog.f --top-module conv1d_tb -o conv1d_sim &&
./obj_dir/conv1d_sim | tee /dev/stderr | grep -qx "RESULT: PASS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
